//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wno-fatal
TOP        = tile_io_tb
FILELIST   = build.f
OBJ_DIR    = obj_dir

.PHONY: lint build sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
hdl/tile_pkg.sv
hdl/mem_cmd_dispatch.sv
hdl/mem_resp_arbiter.sv
hdl/cfg_regs.sv
hdl/clint_slice.sv
hdl/loopback_dev.sv
hdl/tile_io_top.sv
dv/tile_io_tb.sv

//--- dv/tile_io_tb.sv
`timescale 1ns/1ps

module tile_io_tb
  import tile_pkg::*;
();

  localparam int     timeout_c    = 200;
  localparam did_t   my_did_c     = 16'h1234;
  localparam did_t   host_did_c   = 16'habcd;
  localparam paddr_t dram_addr_c  = 32'h8000_1000;
  localparam paddr_t cache_addr_c = {8'h00, cache_dev_c, 20'h0_0040};
  localparam dword_t dram_data_c  = 64'hdead_beef_0123_4567;
  localparam dword_t cache_data_c = 64'h0f1e_2d3c_4b5a_6978;
  localparam dword_t mtime_set_c  = 64'h0000_0100_0000_0000;

  logic     clk_i;
  logic     rst_n_i;
  did_t     my_did_i;
  did_t     host_did_i;
  mem_msg_s mem_cmd_i;
  logic     mem_cmd_v_i;
  logic     mem_cmd_ready_and_o;
  mem_msg_s mem_resp_o;
  logic     mem_resp_v_o;
  logic     mem_resp_yumi_i;
  mem_msg_s ext_cmd_o;
  logic     ext_cmd_v_o;
  logic     ext_cmd_ready_and_i;
  mem_msg_s ext_resp_i;
  logic     ext_resp_v_i;
  logic     ext_resp_yumi_o;
  cfg_bus_s cfg_bus_o;
  logic     timer_irq_o;
  logic     software_irq_o;
  logic     external_irq_o;

  int       errors = 0;
  int       checks = 0;
  int       tests_run = 0;
  integer   seed = 32'hc3e6e81f;

  // External memory model state
  dword_t   mem_model [paddr_t];
  mem_msg_s ext_queue [$];
  mem_msg_s last_ext_cmd;
  int       ext_cmd_count = 0;

  tile_io_top dut (.*);

  always #5 clk_i = ~clk_i;

  function automatic paddr_t local_addr(dev_id_t dev, logic [dev_lsb_c-1:0] offset);
    return {8'h00, dev, offset};
  endfunction

  function automatic mem_msg_s make_msg(mem_op_e op, paddr_t addr, tag_t tag, dword_t data);
    mem_msg_s m;
    m.hdr.op   = op;
    m.hdr.addr = addr;
    m.hdr.tag  = tag;
    m.data     = data;
    return m;
  endfunction

  // Header echoed, data only on reads
  function automatic mem_msg_s expect_resp(mem_msg_s cmd, dword_t rd_data);
    mem_msg_s m;
    m.hdr  = cmd.hdr;
    m.data = (cmd.hdr.op == e_mem_wr) ? '0 : rd_data;
    return m;
  endfunction

  function automatic cfg_bus_s make_cfg(logic freeze, core_id_t core_id);
    cfg_bus_s c;
    c.freeze   = freeze;
    c.core_id  = core_id;
    c.did      = my_did_c;
    c.host_did = host_did_c;
    return c;
  endfunction

  task automatic report_error(string why);
    errors++;
    $display("ERROR: %s", why);
  endtask

  task automatic check_msg(string name, mem_msg_s exp, mem_msg_s act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_hdr(string name, mem_hdr_s exp, mem_hdr_s act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_cfg(string name, cfg_bus_s exp, cfg_bus_s act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_min(string name, dword_t min, dword_t act);
    checks++;
    if (act < min)
    begin
      errors++;
      $display("CHECK FAILED %s: expected >= %h, actual %h", name, min, act);
    end
  endtask

  task automatic send_cmd(mem_msg_s cmd);
    logic ok;
    ok = 1'b0;
    @(negedge clk_i);
    mem_cmd_i   = cmd;
    mem_cmd_v_i = 1'b1;
    for (int n = 0; n < timeout_c; n++)
    begin
      @(posedge clk_i);
      if (mem_cmd_ready_and_o)
      begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok)
      report_error("command was never accepted by the hub");
    @(negedge clk_i);
    mem_cmd_v_i = 1'b0;
  endtask

  // Response is captured on the edge that consumes it
  task automatic get_resp(output mem_msg_s resp);
    logic ok;
    ok   = 1'b0;
    resp = '0;
    for (int n = 0; n < timeout_c; n++)
    begin
      @(posedge clk_i);
      if (mem_resp_v_o)
      begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok)
      report_error("no response came back from the hub");
    else
    begin
      @(negedge clk_i);
      mem_resp_yumi_i = 1'b1;
      @(posedge clk_i);
      resp = mem_resp_o;
      @(negedge clk_i);
      mem_resp_yumi_i = 1'b0;
    end
  endtask

  task automatic do_access(mem_msg_s cmd, output mem_msg_s resp);
    send_cmd(cmd);
    get_resp(resp);
  endtask

  task automatic run_access(string name, mem_op_e op, paddr_t addr, tag_t tag,
                            dword_t wdata, dword_t rdata);
    mem_msg_s cmd;
    mem_msg_s resp;
    cmd = make_msg(op, addr, tag, wdata);
    do_access(cmd, resp);
    check_msg(name, expect_resp(cmd, rdata), resp);
  endtask

  task automatic run_ext_access(string name, mem_op_e op, paddr_t addr, tag_t tag,
                                dword_t wdata, dword_t rdata);
    mem_msg_s cmd;
    mem_msg_s resp;
    cmd = make_msg(op, addr, tag, wdata);
    do_access(cmd, resp);
    check_msg(name, expect_resp(cmd, rdata), resp);
    check_msg({name, " ext cmd"}, cmd, last_ext_cmd);
  endtask

  task automatic report_test(string name, int err_start);
    tests_run++;
    if (errors == err_start)
      $display("%s: ok", name);
    else
      $display("%s: FAIL with %0d errors", name, errors - err_start);
  endtask

  task automatic test_cfg();
    int err_start;
    err_start = errors;
    check_cfg("cfg after reset", make_cfg(1'b1, 8'h00), cfg_bus_o);
    check_bit("resp_v after reset", 1'b0, mem_resp_v_o);
    check_bit("ext_cmd_v after reset", 1'b0, ext_cmd_v_o);
    check_bit("timer_irq after reset", 1'b0, timer_irq_o);
    check_bit("software_irq after reset", 1'b0, software_irq_o);
    check_bit("external_irq after reset", 1'b0, external_irq_o);
    run_access("cfg rd freeze reset", e_mem_rd, local_addr(cfg_dev_c, cfg_freeze_c), 4'h0, '0,
               64'h1);
    run_access("cfg wr freeze", e_mem_wr, local_addr(cfg_dev_c, cfg_freeze_c), 4'h1, 64'h0, '0);
    run_access("cfg wr core_id", e_mem_wr, local_addr(cfg_dev_c, cfg_core_id_c), 4'h2, 64'h5a,
               '0);
    check_cfg("cfg after writes", make_cfg(1'b0, 8'h5a), cfg_bus_o);
    run_access("cfg rd freeze", e_mem_rd, local_addr(cfg_dev_c, cfg_freeze_c), 4'h3, '0, 64'h0);
    run_access("cfg rd core_id", e_mem_rd, local_addr(cfg_dev_c, cfg_core_id_c), 4'h4, '0,
               64'h5a);
    run_access("cfg wr did", e_mem_wr, local_addr(cfg_dev_c, cfg_did_c), 4'h5, 64'hffff, '0);
    run_access("cfg rd did", e_mem_rd, local_addr(cfg_dev_c, cfg_did_c), 4'h6, '0,
               dword_t'(my_did_c));
    run_access("cfg wr host_did", e_mem_wr, local_addr(cfg_dev_c, cfg_host_did_c), 4'h7,
               64'h5555, '0);
    run_access("cfg rd host_did", e_mem_rd, local_addr(cfg_dev_c, cfg_host_did_c), 4'h8, '0,
               dword_t'(host_did_c));
    report_test("configuration block", err_start);
  endtask

  task automatic test_irq();
    int err_start;
    err_start = errors;
    run_access("msip set", e_mem_wr, local_addr(clint_dev_c, clint_msip_c), 4'h1, 64'h1, '0);
    check_bit("software_irq set", 1'b1, software_irq_o);
    run_access("msip rd set", e_mem_rd, local_addr(clint_dev_c, clint_msip_c), 4'h2, '0, 64'h1);
    run_access("msip clear", e_mem_wr, local_addr(clint_dev_c, clint_msip_c), 4'h3, 64'h0, '0);
    check_bit("software_irq clear", 1'b0, software_irq_o);
    run_access("msip rd clear", e_mem_rd, local_addr(clint_dev_c, clint_msip_c), 4'h4, '0, '0);
    run_access("plic set", e_mem_wr, local_addr(clint_dev_c, clint_plic_c), 4'h5, 64'h1, '0);
    check_bit("external_irq set", 1'b1, external_irq_o);
    run_access("plic rd set", e_mem_rd, local_addr(clint_dev_c, clint_plic_c), 4'h6, '0, 64'h1);
    run_access("plic clear", e_mem_wr, local_addr(clint_dev_c, clint_plic_c), 4'h7, 64'h0, '0);
    check_bit("external_irq clear", 1'b0, external_irq_o);
    run_access("plic rd clear", e_mem_rd, local_addr(clint_dev_c, clint_plic_c), 4'h8, '0, '0);
    report_test("software and external interrupts", err_start);
  endtask

  task automatic test_timer();
    int       err_start;
    mem_msg_s cmd;
    mem_msg_s r0;
    mem_msg_s r1;
    err_start = errors;
    cmd = make_msg(e_mem_rd, local_addr(clint_dev_c, clint_mtime_c), 4'h1, '0);
    do_access(cmd, r0);
    check_hdr("mtime rd first hdr", cmd.hdr, r0.hdr);
    cmd.hdr.tag = 4'h2;
    do_access(cmd, r1);
    check_hdr("mtime rd second hdr", cmd.hdr, r1.hdr);
    check_min("mtime increases", r0.data + 64'd1, r1.data);
    run_access("mtimecmp zero", e_mem_wr, local_addr(clint_dev_c, clint_mtimecmp_c), 4'h3,
               64'h0, '0);
    check_bit("timer_irq set", 1'b1, timer_irq_o);
    run_access("mtimecmp ones", e_mem_wr, local_addr(clint_dev_c, clint_mtimecmp_c), 4'h4,
               '1, '0);
    check_bit("timer_irq clear", 1'b0, timer_irq_o);
    run_access("mtimecmp rd", e_mem_rd, local_addr(clint_dev_c, clint_mtimecmp_c), 4'h5,
               '0, '1);
    run_access("mtime wr", e_mem_wr, local_addr(clint_dev_c, clint_mtime_c), 4'h6,
               mtime_set_c, '0);
    cmd.hdr.tag = 4'h7;
    do_access(cmd, r0);
    check_hdr("mtime rd after wr hdr", cmd.hdr, r0.hdr);
    check_min("mtime after wr", mtime_set_c, r0.data);
    report_test("timer", err_start);
  endtask

  task automatic test_ext();
    int err_start;
    int count_start;
    err_start   = errors;
    count_start = ext_cmd_count;
    run_ext_access("dram wr", e_mem_wr, dram_addr_c, 4'h1, dram_data_c, '0);
    run_ext_access("dram rd", e_mem_rd, dram_addr_c, 4'h2, '0, dram_data_c);
    run_ext_access("cache wr", e_mem_wr, cache_addr_c, 4'h3, cache_data_c, '0);
    run_ext_access("cache rd", e_mem_rd, cache_addr_c, 4'h4, '0, cache_data_c);
    if (ext_cmd_count != count_start + 4)
      report_error("external routing: wrong number of commands on the external port");
    report_test("external routing", err_start);
  endtask

  task automatic test_loop();
    int err_start;
    int count_start;
    err_start   = errors;
    count_start = ext_cmd_count;
    run_access("loopback wr", e_mem_wr, local_addr(4'h5, 20'h0_0123), 4'h9,
               64'h1111_2222_3333_4444, '0);
    run_access("loopback rd", e_mem_rd, local_addr(4'hf, 20'hf_ff08), 4'ha, '0, '0);
    if (ext_cmd_count != count_start)
      report_error("loopback: a local command reached the external port");
    report_test("loopback", err_start);
  endtask

  task automatic test_backpressure();
    int       err_start;
    logic     ok;
    mem_msg_s cmd_cfg;
    mem_msg_s cmd_ext;
    mem_msg_s resp;
    err_start = errors;
    cmd_cfg = make_msg(e_mem_rd, local_addr(cfg_dev_c, cfg_host_did_c), 4'hb, '0);
    send_cmd(cmd_cfg);
    repeat (4)
    begin
      @(negedge clk_i);
      check_bit("ready low while cfg resp held", 1'b0, mem_cmd_ready_and_o);
    end
    get_resp(resp);
    check_msg("held cfg resp", expect_resp(cmd_cfg, dword_t'(host_did_c)), resp);
    check_bit("ready after yumi", 1'b1, mem_cmd_ready_and_o);

    // External read and local read both pending
    cmd_ext = make_msg(e_mem_rd, dram_addr_c, 4'hc, '0);
    cmd_cfg = make_msg(e_mem_rd, local_addr(cfg_dev_c, cfg_did_c), 4'hd, '0);
    send_cmd(cmd_ext);
    send_cmd(cmd_cfg);
    ok = 1'b0;
    for (int n = 0; n < timeout_c; n++)
    begin
      @(posedge clk_i);
      if (ext_resp_v_i)
      begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok)
      report_error("external response never arrived");
    else
    begin
      get_resp(resp);
      check_msg("priority ext first", expect_resp(cmd_ext, dram_data_c), resp);
      get_resp(resp);
      check_msg("priority cfg second", expect_resp(cmd_cfg, dword_t'(my_did_c)), resp);
    end
    report_test("back-pressure and priority", err_start);
  endtask

  // External memory model, accepts every command and queues the answer
  always @(posedge clk_i)
  begin : ext_accept
    mem_msg_s resp;
    if (rst_n_i && ext_cmd_v_o && ext_cmd_ready_and_i)
    begin
      last_ext_cmd = ext_cmd_o;
      ext_cmd_count++;
      resp.hdr = ext_cmd_o.hdr;
      if (ext_cmd_o.hdr.op == e_mem_wr)
      begin
        mem_model[ext_cmd_o.hdr.addr] = ext_cmd_o.data;
        resp.data = '0;
      end
      else if (mem_model.exists(ext_cmd_o.hdr.addr))
        resp.data = mem_model[ext_cmd_o.hdr.addr];
      else
        resp.data = {ext_cmd_o.hdr.addr, ~ext_cmd_o.hdr.addr};
      ext_queue.push_back(resp);
    end
  end

  initial
  begin : ext_responder
    int   delay;
    logic ok;
    ext_cmd_ready_and_i = 1'b1;
    ext_resp_i          = '0;
    ext_resp_v_i        = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (ext_queue.size() > 0)
      begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_i);
        ext_resp_i   = ext_queue[0];
        ext_resp_v_i = 1'b1;
        ok = 1'b0;
        for (int n = 0; n < timeout_c; n++)
        begin
          @(posedge clk_i);
          if (ext_resp_yumi_o)
          begin
            ok = 1'b1;
            break;
          end
        end
        if (!ok)
          report_error("external response was never consumed");
        void'(ext_queue.pop_front());
        @(negedge clk_i);
        ext_resp_v_i = 1'b0;
      end
    end
  end

  initial
  begin
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    my_did_i        = my_did_c;
    host_did_i      = host_did_c;
    mem_cmd_i       = '0;
    mem_cmd_v_i     = 1'b0;
    mem_resp_yumi_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    test_cfg();
    test_irq();
    test_timer();
    test_ext();
    test_loop();
    test_backpressure();

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- hdl/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_and_o,

  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i,

  input  did_t     did_i,
  input  did_t     host_did_i,
  output cfg_bus_s cfg_bus_o
);

  logic                 freeze_r;
  core_id_t             core_id_r;
  logic                 resp_v_r;
  mem_msg_s             resp_r;
  logic [dev_lsb_c-1:0] offset;
  logic                 cmd_accept;
  logic                 is_wr;
  dword_t               rdata;

  assign offset     = cmd_i.hdr.addr[dev_lsb_c-1:0];
  assign cmd_accept = cmd_v_i & cmd_ready_and_o;
  assign is_wr      = (cmd_i.hdr.op == e_mem_wr);

  // Read mux, unmapped offsets give zero
  always_comb
  begin
    case (offset)
      cfg_freeze_c:   rdata = dword_t'(freeze_r);
      cfg_core_id_c:  rdata = dword_t'(core_id_r);
      cfg_did_c:      rdata = dword_t'(did_i);
      cfg_host_did_c: rdata = dword_t'(host_did_i);
      default:        rdata = '0;
    endcase
  end

  // Core held frozen until software releases it
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r  <= 1'b1;
      core_id_r <= '0;
    end
    else if (cmd_accept && is_wr)
    begin
      if (offset == cfg_freeze_c)
        freeze_r <= cmd_i.data[0];
      if (offset == cfg_core_id_c)
        core_id_r <= cmd_i.data[$bits(core_id_t)-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
    begin
      resp_r.hdr  <= cmd_i.hdr;
      resp_r.data <= is_wr ? '0 : rdata;
    end
  end

  assign cmd_ready_and_o = ~resp_v_r;
  assign resp_o          = resp_r;
  assign resp_v_o        = resp_v_r;

  assign cfg_bus_o = '{freeze: freeze_r, core_id: core_id_r, did: did_i, host_did: host_did_i};

endmodule

//--- hdl/clint_slice.sv
`timescale 1ns/1ps

module clint_slice
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_and_o,

  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i,

  output logic     timer_irq_o,
  output logic     software_irq_o,
  output logic     external_irq_o
);

  dword_t               mtime_r;
  dword_t               mtimecmp_r;
  logic                 msip_r;
  logic                 plic_r;
  logic                 resp_v_r;
  mem_msg_s             resp_r;
  logic [dev_lsb_c-1:0] offset;
  logic                 cmd_accept;
  logic                 wr_en;
  dword_t               rdata;

  assign offset     = cmd_i.hdr.addr[dev_lsb_c-1:0];
  assign cmd_accept = cmd_v_i & cmd_ready_and_o;
  assign wr_en      = cmd_accept & (cmd_i.hdr.op == e_mem_wr);

  always_comb
  begin
    case (offset)
      clint_msip_c:     rdata = dword_t'(msip_r);
      clint_mtimecmp_c: rdata = mtimecmp_r;
      clint_plic_c:     rdata = dword_t'(plic_r);
      clint_mtime_c:    rdata = mtime_r;
      default:          rdata = '0;
    endcase
  end

  // Free-running timer, a write replaces the count
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      mtime_r <= '0;
    else if (wr_en && (offset == clint_mtime_c))
      mtime_r <= cmd_i.data;
    else
      mtime_r <= mtime_r + 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      plic_r     <= 1'b0;
    end
    else if (wr_en)
    begin
      if (offset == clint_mtimecmp_c)
        mtimecmp_r <= cmd_i.data;
      if (offset == clint_msip_c)
        msip_r <= cmd_i.data[0];
      if (offset == clint_plic_c)
        plic_r <= cmd_i.data[0];
    end
  end

  // One response slot
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
    begin
      resp_r.hdr  <= cmd_i.hdr;
      resp_r.data <= wr_en ? '0 : rdata;
    end
  end

  assign cmd_ready_and_o = ~resp_v_r;
  assign resp_o          = resp_r;
  assign resp_v_o        = resp_v_r;

  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;
  assign external_irq_o = plic_r;

endmodule

//--- hdl/loopback_dev.sv
`timescale 1ns/1ps

module loopback_dev
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_and_o,

  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i
);

  logic     resp_v_r;
  mem_hdr_s resp_hdr_r;
  logic     cmd_accept;

  assign cmd_accept = cmd_v_i & cmd_ready_and_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  // Only the header is kept, data always answers zero
  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
      resp_hdr_r <= cmd_i.hdr;
  end

  assign cmd_ready_and_o = ~resp_v_r;
  assign resp_o          = '{hdr: resp_hdr_r, data: '0};
  assign resp_v_o        = resp_v_r;

endmodule

//--- hdl/mem_cmd_dispatch.sv
`timescale 1ns/1ps

module mem_cmd_dispatch
  import tile_pkg::*;
(
  input  mem_msg_s   mem_cmd_i,
  input  logic       mem_cmd_v_i,
  output logic       mem_cmd_ready_and_o,

  output mem_msg_s   tgt_cmd_o,
  output logic [3:0] tgt_v_o,
  input  logic [3:0] ready_and_i
);

  paddr_t     addr;
  dev_id_t    dev;
  logic       local_cmd;
  logic       handoff;
  logic [3:0] sel_oh;

  assign addr      = mem_cmd_i.hdr.addr;
  assign dev       = addr[dev_lsb_c+:$bits(dev_id_t)];
  assign local_cmd = (addr < dram_base_c);

  // One-hot target select
  always_comb
  begin
    sel_oh = '0;
    if (!local_cmd || (dev == cache_dev_c))
      sel_oh[tgt_mem] = 1'b1;
    else if (dev == cfg_dev_c)
      sel_oh[tgt_cfg] = 1'b1;
    else if (dev == clint_dev_c)
      sel_oh[tgt_clint] = 1'b1;
    else
      sel_oh[tgt_loop] = 1'b1;
  end

  // Source sees ready only when every target can take the command
  assign mem_cmd_ready_and_o = &ready_and_i;

  // Gate valids with the full handshake so a ready target never
  // consumes a command the source still holds
  assign handoff = mem_cmd_v_i & mem_cmd_ready_and_o;
  assign tgt_v_o = sel_oh & {4{handoff}};

  assign tgt_cmd_o = mem_cmd_i;

endmodule

//--- hdl/mem_resp_arbiter.sv
`timescale 1ns/1ps

module mem_resp_arbiter
  import tile_pkg::*;
(
  input  mem_msg_s [3:0] resp_i,
  input  logic [3:0]     resp_v_i,
  output logic [3:0]     resp_yumi_o,

  output mem_msg_s       mem_resp_o,
  output logic           mem_resp_v_o,
  input  logic           mem_resp_yumi_i
);

  tgt_e       sel;
  logic [3:0] grant;

  // Scan down so the lowest valid index is the last one kept
  always_comb
  begin
    sel = tgt_loop;
    for (int i = 3; i >= 0; i--)
    begin
      if (resp_v_i[i])
        sel = tgt_e'(i[1:0]);
    end
  end

  always_comb
  begin
    grant      = '0;
    grant[sel] = |resp_v_i;
  end

  assign mem_resp_o   = resp_i[sel];
  assign mem_resp_v_o = |resp_v_i;

  // Only the granted source sees the consume
  assign resp_yumi_o = grant & {4{mem_resp_yumi_i}};

endmodule

//--- hdl/tile_io_top.sv
`timescale 1ns/1ps

module tile_io_top
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  did_t     my_did_i,
  input  did_t     host_did_i,

  input  mem_msg_s mem_cmd_i,
  input  logic     mem_cmd_v_i,
  output logic     mem_cmd_ready_and_o,

  output mem_msg_s mem_resp_o,
  output logic     mem_resp_v_o,
  input  logic     mem_resp_yumi_i,

  output mem_msg_s ext_cmd_o,
  output logic     ext_cmd_v_o,
  input  logic     ext_cmd_ready_and_i,

  input  mem_msg_s ext_resp_i,
  input  logic     ext_resp_v_i,
  output logic     ext_resp_yumi_o,

  output cfg_bus_s cfg_bus_o,
  output logic     timer_irq_o,
  output logic     software_irq_o,
  output logic     external_irq_o
);

  mem_msg_s       tgt_cmd;
  logic [3:0]     tgt_v;
  logic [3:0]     tgt_ready;
  mem_msg_s [3:0] tgt_resp;
  logic [3:0]     tgt_resp_v;
  logic [3:0]     tgt_resp_yumi;

  logic     cfg_ready, clint_ready, loop_ready;
  mem_msg_s cfg_resp, clint_resp, loop_resp;
  logic     cfg_resp_v, clint_resp_v, loop_resp_v;

  // Slots packed in tgt_e order, memory slot is the external port
  assign tgt_ready  = {loop_ready, clint_ready, cfg_ready, ext_cmd_ready_and_i};
  assign tgt_resp   = {loop_resp, clint_resp, cfg_resp, ext_resp_i};
  assign tgt_resp_v = {loop_resp_v, clint_resp_v, cfg_resp_v, ext_resp_v_i};

  assign ext_cmd_o       = tgt_cmd;
  assign ext_cmd_v_o     = tgt_v[tgt_mem];
  assign ext_resp_yumi_o = tgt_resp_yumi[tgt_mem];

  mem_cmd_dispatch u_dispatch (
    .mem_cmd_i           (mem_cmd_i),
    .mem_cmd_v_i         (mem_cmd_v_i),
    .mem_cmd_ready_and_o (mem_cmd_ready_and_o),
    .tgt_cmd_o           (tgt_cmd),
    .tgt_v_o             (tgt_v),
    .ready_and_i         (tgt_ready)
  );

  mem_resp_arbiter u_arbiter (
    .resp_i          (tgt_resp),
    .resp_v_i        (tgt_resp_v),
    .resp_yumi_o     (tgt_resp_yumi),
    .mem_resp_o      (mem_resp_o),
    .mem_resp_v_o    (mem_resp_v_o),
    .mem_resp_yumi_i (mem_resp_yumi_i)
  );

  cfg_regs u_cfg (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_i           (tgt_cmd),
    .cmd_v_i         (tgt_v[tgt_cfg]),
    .cmd_ready_and_o (cfg_ready),
    .resp_o          (cfg_resp),
    .resp_v_o        (cfg_resp_v),
    .resp_yumi_i     (tgt_resp_yumi[tgt_cfg]),
    .did_i           (my_did_i),
    .host_did_i      (host_did_i),
    .cfg_bus_o       (cfg_bus_o)
  );

  clint_slice u_clint (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_i           (tgt_cmd),
    .cmd_v_i         (tgt_v[tgt_clint]),
    .cmd_ready_and_o (clint_ready),
    .resp_o          (clint_resp),
    .resp_v_o        (clint_resp_v),
    .resp_yumi_i     (tgt_resp_yumi[tgt_clint]),
    .timer_irq_o     (timer_irq_o),
    .software_irq_o  (software_irq_o),
    .external_irq_o  (external_irq_o)
  );

  loopback_dev u_loopback (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_i           (tgt_cmd),
    .cmd_v_i         (tgt_v[tgt_loop]),
    .cmd_ready_and_o (loop_ready),
    .resp_o          (loop_resp),
    .resp_v_o        (loop_resp_v),
    .resp_yumi_i     (tgt_resp_yumi[tgt_loop])
  );

endmodule

//--- hdl/tile_pkg.sv
package tile_pkg;

  // Basic widths
  typedef logic [31:0] paddr_t;
  typedef logic [63:0] dword_t;
  typedef logic [15:0] did_t;
  typedef logic [7:0]  core_id_t;
  typedef logic [3:0]  dev_id_t;
  typedef logic [3:0]  tag_t;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Single-beat memory message
  typedef struct packed
  {
    mem_op_e op;
    paddr_t  addr;
    tag_t    tag;
  } mem_hdr_s;

  typedef struct packed
  {
    mem_hdr_s hdr;
    dword_t   data;
  } mem_msg_s;

  // Configuration bus toward the tile
  typedef struct packed
  {
    logic     freeze;
    core_id_t core_id;
    did_t     did;
    did_t     host_did;
  } cfg_bus_s;

  // Address map
  localparam paddr_t dram_base_c = 32'h8000_0000;

  // Device field sits just above the local offset
  localparam int dev_lsb_c = 20;

  localparam dev_id_t clint_dev_c = 4'd1;
  localparam dev_id_t cfg_dev_c   = 4'd2;
  localparam dev_id_t cache_dev_c = 4'd3;

  // Configuration block offsets
  localparam logic [dev_lsb_c-1:0] cfg_freeze_c   = 20'h0_0000;
  localparam logic [dev_lsb_c-1:0] cfg_core_id_c  = 20'h0_0008;
  localparam logic [dev_lsb_c-1:0] cfg_did_c      = 20'h0_0010;
  localparam logic [dev_lsb_c-1:0] cfg_host_did_c = 20'h0_0018;

  // CLINT offsets
  localparam logic [dev_lsb_c-1:0] clint_msip_c     = 20'h0_0000;
  localparam logic [dev_lsb_c-1:0] clint_mtimecmp_c = 20'h0_4000;
  localparam logic [dev_lsb_c-1:0] clint_plic_c     = 20'h0_b000;
  localparam logic [dev_lsb_c-1:0] clint_mtime_c    = 20'h0_bff8;

  // Response sources, lowest value wins arbitration
  typedef enum logic [1:0]
  {
    tgt_mem   = 2'd0,
    tgt_cfg   = 2'd1,
    tgt_clint = 2'd2,
    tgt_loop  = 2'd3
  } tgt_e;

endpackage
